// File: src/pw_pkg.sv
package pw_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////
   localparam int PATTERN_BYTES = 8;                         // pattern and history depth
   localparam int LEN_WIDTH     = $clog2(PATTERN_BYTES + 1); // holds 0..PATTERN_BYTES
   localparam int DELAY_WIDTH   = 20;
   localparam int WIDTH_WIDTH   = 17;
   localparam int NUM_PULSES    = 4;                         // default stage count

   typedef logic [7:0]                   fe_byte_t;
   typedef logic [8*PATTERN_BYTES-1:0]   pattern_t;  // byte 0 is the newest byte
   typedef logic [LEN_WIDTH-1:0]         len_t;
   typedef logic [DELAY_WIDTH-1:0]       delay_t;
   typedef logic [WIDTH_WIDTH-1:0]       width_t;

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////
   localparam fe_byte_t ADDR_PATTERN     = 8'h00;  // 0x00..0x07
   localparam fe_byte_t ADDR_MASK        = 8'h08;  // 0x08..0x0f
   localparam fe_byte_t ADDR_PATTERN_LEN = 8'h10;  // compared bytes, 1..8
   localparam fe_byte_t ADDR_NUM_PULSES  = 8'h11;  // pulses per match
   localparam fe_byte_t ADDR_ARM         = 8'h12;  // bit 0 arms the matcher
   localparam fe_byte_t ADDR_PULSE_BASE  = 8'h20;  // pulse k at base + 8k

   // byte offsets inside one pulse block
   localparam int OFS_DELAY  = 0;  // +0..+2, lsb first
   localparam int OFS_WIDTH  = 3;  // +3..+5, lsb first
   localparam int FIELD_BYTES = 3;

endpackage

// File: src/match_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// pattern configuration from the register file to the matcher
interface match_cfg_if;

   pw_pkg::pattern_t pattern;
   pw_pkg::pattern_t mask;
   pw_pkg::len_t     pattern_len;
   logic             arm;
   logic             disarm;     // one-cycle pulse back from the matcher

   modport regs (
      output pattern, mask, pattern_len, arm,
      input  disarm
   );

   modport matcher (
      input  pattern, mask, pattern_len, arm,
      output disarm
   );

endinterface

`default_nettype wire

// File: src/pw_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module pw_reg_file #(
   parameter int num_pulses_p = pw_pkg::NUM_PULSES
) (
   input  wire                 fe_clk,
   input  wire                 rst_i,
   input  wire [7:0]           reg_addr_i,
   input  wire [7:0]           reg_wdata_i,
   input  wire                 reg_write_i,
   match_cfg_if.regs           cfg_o,
   output pw_pkg::delay_t      delays_o [num_pulses_p],
   output pw_pkg::width_t      widths_o [num_pulses_p],
   output pw_pkg::fe_byte_t    num_pulses_o,
   output logic                led_arm_o
);

   logic [7:0] pulse_rel;   // address relative to the pulse block base
   logic       pulse_sel;
   int         pulse_idx;
   logic [2:0] pulse_ofs;

   // drop one byte into a 24-bit field, lsb first
   function automatic logic [23:0] put_byte(logic [23:0] cur, int unsigned ofs,
                                            pw_pkg::fe_byte_t b);
      logic [23:0] v;
      v = cur;
      v[8*ofs +: 8] = b;
      return v;
   endfunction

   ////////////////////////////////////////
   // address decode
   ////////////////////////////////////////
   always_comb begin
      pulse_rel = reg_addr_i - pw_pkg::ADDR_PULSE_BASE;
      pulse_idx = int'(pulse_rel[7:3]);
      pulse_ofs = pulse_rel[2:0];
      pulse_sel = (reg_addr_i >= pw_pkg::ADDR_PULSE_BASE) && (pulse_idx < num_pulses_p);
   end

   ////////////////////////////////////////
   // register writes
   ////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         cfg_o.pattern     <= '0;
         cfg_o.mask        <= '0;
         cfg_o.pattern_len <= pw_pkg::len_t'(1);
         cfg_o.arm         <= 1'b0;
         num_pulses_o      <= 8'd1;
         for (int k = 0; k < num_pulses_p; k++) begin
            delays_o[k] <= '0;
            widths_o[k] <= pw_pkg::width_t'(1);
         end
      end else begin
         if (cfg_o.disarm)
            cfg_o.arm <= 1'b0;          // a write below still wins
         if (reg_write_i) begin
            if ((reg_addr_i & 8'hf8) == pw_pkg::ADDR_PATTERN)
               cfg_o.pattern[8*reg_addr_i[2:0] +: 8] <= reg_wdata_i;
            else if ((reg_addr_i & 8'hf8) == pw_pkg::ADDR_MASK)
               cfg_o.mask[8*reg_addr_i[2:0] +: 8] <= reg_wdata_i;
            else if (reg_addr_i == pw_pkg::ADDR_PATTERN_LEN)
               cfg_o.pattern_len <= reg_wdata_i[pw_pkg::LEN_WIDTH-1:0];
            else if (reg_addr_i == pw_pkg::ADDR_NUM_PULSES)
               num_pulses_o <= reg_wdata_i;
            else if (reg_addr_i == pw_pkg::ADDR_ARM)
               cfg_o.arm <= reg_wdata_i[0];
            else if (pulse_sel) begin
               if (pulse_ofs < pw_pkg::OFS_WIDTH)
                  delays_o[pulse_idx] <= pw_pkg::delay_t'(put_byte(24'(delays_o[pulse_idx]),
                     pulse_ofs - pw_pkg::OFS_DELAY, reg_wdata_i));
               else if (pulse_ofs < pw_pkg::OFS_WIDTH + pw_pkg::FIELD_BYTES)
                  widths_o[pulse_idx] <= pw_pkg::width_t'(put_byte(24'(widths_o[pulse_idx]),
                     pulse_ofs - pw_pkg::OFS_WIDTH, reg_wdata_i));
               // offsets +6, +7 unused
            end
         end
      end
   end

   assign led_arm_o = cfg_o.arm;

endmodule

`default_nettype wire

// File: src/pattern_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher (
   input  wire                fe_clk,
   input  wire                rst_i,
   input  wire [7:0]          fe_data_i,
   input  wire                fe_rxvalid_i,
   input  wire                fe_rxactive_i,
   match_cfg_if.matcher       cfg_i,
   output logic               match_o
);

   localparam int N = pw_pkg::PATTERN_BYTES;

   pw_pkg::pattern_t hist;        // newest byte in bits 7:0
   pw_pkg::pattern_t hist_nxt;
   pw_pkg::len_t     cnt;         // bytes seen this packet, saturates at N
   pw_pkg::len_t     cnt_nxt;
   logic             hit;
   logic             fire;

   ////////////////////////////////////////
   // masked compare on the shifted history
   ////////////////////////////////////////
   always_comb begin
      hist_nxt = {hist[8*(N-1)-1:0], fe_data_i};
      cnt_nxt  = (cnt == N) ? cnt : cnt + 1'b1;
      hit      = 1'b1;
      for (int i = 0; i < N; i++) begin
         if ((i < cfg_i.pattern_len) &&
             (((hist_nxt[8*i +: 8] ^ cfg_i.pattern[8*i +: 8]) & cfg_i.mask[8*i +: 8]) != 8'h00))
            hit = 1'b0;
      end
      // no second fire while the disarm is still in flight
      fire = cfg_i.arm && !match_o && fe_rxvalid_i && fe_rxactive_i &&
             (cnt_nxt >= cfg_i.pattern_len) && hit;
   end

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         cnt     <= '0;
         match_o <= 1'b0;
      end else begin
         match_o <= fire;
         if (!fe_rxactive_i) begin
            hist <= '0;             // history never spans packets
            cnt  <= '0;
         end else if (fe_rxvalid_i) begin
            hist <= hist_nxt;
            cnt  <= cnt_nxt;
         end
      end
   end

   assign cfg_i.disarm = match_o;   // one shot per arm

endmodule

`default_nettype wire

// File: src/trigger_pulse_stage.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse_stage #(
   parameter int idx_p = 0
) (
   input  wire                 fe_clk,
   input  wire                 rst_i,
   input  wire                 start_i,
   input  pw_pkg::delay_t      delay_i,
   input  pw_pkg::width_t      width_i,
   input  pw_pkg::fe_byte_t    num_pulses_i,
   output logic                pulse_o,
   output logic                done_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_HIGH
   } state_t;

   state_t         state;
   pw_pkg::delay_t cnt;         // shared by delay and width phases
   pw_pkg::width_t width_eff;
   logic           enabled;

   assign width_eff = (width_i == '0) ? pw_pkg::width_t'(1) : width_i;
   assign enabled   = (idx_p < num_pulses_i);   // stages past num_pulses stay idle

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: if (start_i && enabled) begin
               state <= ST_DELAY;
               cnt   <= delay_i;
            end
            ST_DELAY: if (cnt == '0) begin
               state <= ST_HIGH;
               cnt   <= pw_pkg::delay_t'(width_eff - 1'b1);
            end else begin
               cnt <= cnt - 1'b1;
            end
            ST_HIGH: if (cnt == '0) begin
               state <= ST_IDLE;
            end else begin
               cnt <= cnt - 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign pulse_o = (state == ST_HIGH);
   assign done_o  = pulse_o && (cnt == '0);   // last high cycle

endmodule

`default_nettype wire

// File: src/trigger_output.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_output #(
   parameter int num_pulses_p = pw_pkg::NUM_PULSES
) (
   input  wire                     fe_clk,
   input  wire                     rst_i,
   input  wire [num_pulses_p-1:0]  pulses_i,
   input  wire                     match_i,
   output logic                    cw_trig_o,
   output logic [3:0]              pulse_count_o
);

   logic any_pulse;
   logic rise;

   assign any_pulse = |pulses_i;
   assign rise      = any_pulse && !cw_trig_o;  // cw_trig_o is last cycle's OR

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         cw_trig_o     <= 1'b0;
         pulse_count_o <= '0;
      end else begin
         cw_trig_o <= any_pulse;
         if (match_i)
            pulse_count_o <= '0;        // new trigger sequence
         else if (rise)
            pulse_count_o <= pulse_count_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/phywhisperer_top.sv
`timescale 1ns/1ps
`default_nettype none

module phywhisperer_top #(
   parameter int num_pulses_p = pw_pkg::NUM_PULSES
) (
   input  wire        fe_clk,
   input  wire        rst_i,
   input  wire [7:0]  fe_data_i,
   input  wire        fe_rxvalid_i,
   input  wire        fe_rxactive_i,
   input  wire [7:0]  reg_addr_i,
   input  wire [7:0]  reg_wdata_i,
   input  wire        reg_write_i,
   output wire        cw_trig_o,
   output wire        led_arm_o,
   output wire [3:0]  pulse_count_o
);

   match_cfg_if        match_cfg ();

   pw_pkg::delay_t     delays [num_pulses_p];
   pw_pkg::width_t     widths [num_pulses_p];
   pw_pkg::fe_byte_t   num_pulses;
   logic               match;
   logic [num_pulses_p-1:0] start;    // start[k] feeds stage k
   logic [num_pulses_p-1:0] pulse;

   pw_reg_file #(
      .num_pulses_p  (num_pulses_p)
   ) u_reg_file (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .reg_addr_i    (reg_addr_i),
      .reg_wdata_i   (reg_wdata_i),
      .reg_write_i   (reg_write_i),
      .cfg_o         (match_cfg.regs),
      .delays_o      (delays),
      .widths_o      (widths),
      .num_pulses_o  (num_pulses),
      .led_arm_o     (led_arm_o)
   );

   pattern_matcher u_matcher (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .cfg_i         (match_cfg.matcher),
      .match_o       (match)
   );

   assign start[0] = match;

   ////////////////////////////////////////
   // pulse chain where done of k starts k+1
   ////////////////////////////////////////
   for (genvar k = 0; k < num_pulses_p; k++) begin : g_stage
      logic done;

      trigger_pulse_stage #(
         .idx_p        (k)
      ) u_stage (
         .fe_clk       (fe_clk),
         .rst_i        (rst_i),
         .start_i      (start[k]),
         .delay_i      (delays[k]),
         .width_i      (widths[k]),
         .num_pulses_i (num_pulses),
         .pulse_o      (pulse[k]),
         .done_o       (done)
      );

      if (k < num_pulses_p - 1) begin : g_link
         assign start[k+1] = done;
      end
   end

   trigger_output #(
      .num_pulses_p  (num_pulses_p)
   ) u_output (
      .fe_clk        (fe_clk),
      .rst_i         (rst_i),
      .pulses_i      (pulse),
      .match_i       (match),
      .cw_trig_o     (cw_trig_o),
      .pulse_count_o (pulse_count_o)
   );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int period_ns_p    = 100,
   parameter int reset_cycles_p = 3
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(period_ns_p / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (reset_cycles_p) @(posedge clk_o);
      @(negedge clk_o);
      rst_o <= 1'b0;   // released on a falling edge
   end

endmodule

// File: tb/phywhisperer_props.sv
`timescale 1ns/1ps

module phywhisperer_props #(
   parameter int num_pulses_p = pw_pkg::NUM_PULSES
) (
   input wire       clk_i,
   input wire       rst_i,
   input wire       trig_i,
   input wire       arm_i,
   input wire       match_i,
   input wire [3:0] count_i
);

   int unsigned violations = 0;

   // count and pin update on the same edge, so look at the old count
   a_no_extra_rise: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(trig_i) |-> ($past(count_i) != 4'(num_pulses_p)))
      else begin
         violations++;
         $error("trigger pin rose with the pulse count already at the stage count");
      end

   a_match_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      match_i |=> !match_i)
      else begin
         violations++;
         $error("matcher output high in two consecutive cycles");
      end

   a_disarm_after_match: assert property (@(posedge clk_i) disable iff (rst_i)
      match_i |-> ##[0:2] !arm_i)   // disarm pulse, then arm bit clears
      else begin
         violations++;
         $error("arm LED still on two cycles after a match");
      end

endmodule

bind phywhisperer_top phywhisperer_props #(.num_pulses_p(num_pulses_p)) u_props (
   .clk_i   (fe_clk),
   .rst_i   (rst_i),
   .trig_i  (cw_trig_o),
   .arm_i   (led_arm_o),
   .match_i (match),
   .count_i (pulse_count_o)
);

// File: tb/phywhisperer_tb.sv
`timescale 1ns/1ps

module phywhisperer_tb;

   localparam int num_pulses_p = pw_pkg::NUM_PULSES;
   localparam int num_cases    = 8;

   typedef struct packed {
      logic [63:0]      pattern;    // byte 0 is the newest byte
      logic [63:0]      mask;
      logic [7:0]       len;
      logic [7:0]       npulses;
      logic [3:0][19:0] delay;
      logic [3:0][16:0] width;
      logic             do_arm;
      logic [7:0]       nfill;      // random bytes ahead of pkt
      logic [63:0]      pkt;        // sent from byte nbytes-1 down to byte 0
      logic [7:0]       nbytes;
      logic             split;      // rxactive drops before pkt byte gap_at
      logic [7:0]       gap_at;
      logic             echo;       // final byte sent twice in a row
      logic             expect_trig;
   } case_t;

   logic       clk;
   logic       rst;
   logic [7:0] fe_data;
   logic       fe_rxvalid;
   logic       fe_rxactive;
   logic [7:0] reg_addr;
   logic [7:0] reg_wdata;
   logic       reg_write;
   wire        cw_trig;
   wire        led_arm;
   wire  [3:0] pulse_count;

   case_t       cases [num_cases];
   int          cyc = 0;
   int          limit;
   logic [31:0] rng = 32'he6010dd7;
   logic        trig_q;
   int          rises[$];
   int          falls[$];
   int          exp_rise [4];
   int          exp_fall [4];

   tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

   phywhisperer_top #(
      .num_pulses_p  (num_pulses_p)
   ) dut (
      .fe_clk        (clk),
      .rst_i         (rst),
      .fe_data_i     (fe_data),
      .fe_rxvalid_i  (fe_rxvalid),
      .fe_rxactive_i (fe_rxactive),
      .reg_addr_i    (reg_addr),
      .reg_wdata_i   (reg_wdata),
      .reg_write_i   (reg_write),
      .cw_trig_o     (cw_trig),
      .led_arm_o     (led_arm),
      .pulse_count_o (pulse_count)
   );

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("TEST FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic check(input bit ok, input string msg);
      assert (ok) else begin
         $display("[FAIL] %0t ns: %s", $time, msg);
         $display("TEST FAILED");
         $fatal(1, "check failed");
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // redraw fillers that would pass the compare on pattern byte 0
   task automatic next_filler(input case_t c, output logic [7:0] b);
      do begin
         rng = xorshift32(rng);
         b   = rng[7:0];
      end while (((b ^ c.pattern[7:0]) & c.mask[7:0]) == 8'h00);
   endtask

   // one falling edge; trigger edges logged in cycle numbers
   task automatic tick();
      @(negedge clk);
      if (cw_trig && !trig_q)
         rises.push_back(cyc);
      if (!cw_trig && trig_q)
         falls.push_back(cyc);
      trig_q = cw_trig;
      check(dut.u_props.violations == 0, "bound property checker flagged a violation");
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      reg_addr  = addr;
      reg_wdata = data;
      reg_write = 1'b1;
      tick();
      reg_write = 1'b0;
   endtask

   task automatic send_byte(input logic [7:0] b);
      fe_data    = b;
      fe_rxvalid = 1'b1;
      tick();
      fe_rxvalid = 1'b0;
   endtask

   ////////////////////////////////////////
   // case setup and stimulus
   ////////////////////////////////////////
   task automatic program_case(input case_t c);
      for (int i = 0; i < 8; i++) begin
         write_reg(8'(pw_pkg::ADDR_PATTERN + i), c.pattern[8*i +: 8]);
         write_reg(8'(pw_pkg::ADDR_MASK + i), c.mask[8*i +: 8]);
      end
      write_reg(pw_pkg::ADDR_PATTERN_LEN, c.len);
      write_reg(pw_pkg::ADDR_NUM_PULSES, c.npulses);
      for (int k = 0; k < 4; k++) begin
         for (int b = 0; b < 3; b++) begin
            write_reg(8'(pw_pkg::ADDR_PULSE_BASE + 8*k + b), 8'(c.delay[k] >> (8*b)));
            write_reg(8'(pw_pkg::ADDR_PULSE_BASE + 8*k + 3 + b), 8'(c.width[k] >> (8*b)));
         end
      end
      if (c.do_arm)
         write_reg(pw_pkg::ADDR_ARM, 8'h01);
   endtask

   task automatic send_packet(input case_t c, output int e_edge);
      logic [7:0] b;
      fe_rxactive = 1'b1;
      tick();
      for (int i = 0; i < int'(c.nfill); i++) begin
         next_filler(c, b);
         send_byte(b);
      end
      for (int i = int'(c.nbytes) - 1; i >= 0; i--) begin
         if (c.split && i == int'(c.gap_at)) begin
            fe_rxactive = 1'b0;        // packet boundary
            tick();
            tick();
            fe_rxactive = 1'b1;
            tick();
         end
         if (i == 0)
            e_edge = cyc + 1;          // edge that samples the final byte
         send_byte(c.pkt[8*i +: 8]);
      end
      for (int i = 0; i < 2; i++) begin
         if (c.echo && i == 0)
            b = c.pkt[7:0];            // matches again while the disarm is pending
         else
            next_filler(c, b);
         send_byte(b);
      end
      fe_rxactive = 1'b0;
      tick();
   endtask

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic int pulse_span(input case_t c);
      int s;
      s = 3;
      for (int k = 0; k < int'(c.npulses); k++)
         s += int'(c.delay[k]) + ((c.width[k] == 0) ? 1 : int'(c.width[k])) + 1;
      return s;
   endfunction

   task automatic predict_pulses(input case_t c, input int e_edge);
      int t;
      t = e_edge + 2;                  // match register plus output register
      for (int k = 0; k < int'(c.npulses); k++) begin
         t = t + int'(c.delay[k]) + 1;
         exp_rise[k] = t;
         t = t + ((c.width[k] == 0) ? 1 : int'(c.width[k]));
         exp_fall[k] = t;
      end
   endtask

   task automatic run_case(input int n);
      case_t c;
      int    e_edge;
      c = cases[n];
      rises.delete();
      falls.delete();
      program_case(c);
      check(led_arm === c.do_arm,
            $sformatf("case %0d arm LED is %b before the packet", n, led_arm));
      send_packet(c, e_edge);
      predict_pulses(c, e_edge);
      if (c.expect_trig) begin
         while (falls.size() < int'(c.npulses))
            tick();
      end
      while (cyc < e_edge + pulse_span(c) + 4)
         tick();
      if (c.expect_trig) begin
         check(rises.size() == int'(c.npulses) && falls.size() == int'(c.npulses),
               $sformatf("case %0d saw %0d pulses, expected %0d", n, rises.size(), c.npulses));
         for (int k = 0; k < int'(c.npulses); k++) begin
            check(rises[k] == exp_rise[k],
                  $sformatf("case %0d pulse %0d rose at cycle %0d, expected %0d",
                            n, k, rises[k], exp_rise[k]));
            check(falls[k] == exp_fall[k],
                  $sformatf("case %0d pulse %0d fell at cycle %0d, expected %0d",
                            n, k, falls[k], exp_fall[k]));
         end
         check(pulse_count === 4'(c.npulses),
               $sformatf("case %0d pulse count is %0d, expected %0d", n, pulse_count, c.npulses));
         check(led_arm === 1'b0, $sformatf("case %0d arm LED still on after the trigger", n));
      end else begin
         check(rises.size() == 0,
               $sformatf("case %0d gave %0d pulses, expected none", n, rises.size()));
      end
   endtask

   task automatic load_cases();
      // full mask, 4 bytes, one pulse of delay 5 and width 3
      cases[0] = '{pattern: 64'h3e81_c35a, mask: 64'hffff_ffff, len: 8'd4, npulses: 8'd1,
                   delay: {20'd0, 20'd0, 20'd0, 20'd5}, width: {17'd1, 17'd1, 17'd1, 17'd3},
                   do_arm: 1'b1, nfill: 8'd3, pkt: 64'h3e81_c35a, nbytes: 8'd4,
                   split: 1'b0, gap_at: 8'd0, echo: 1'b0, expect_trig: 1'b1};
      // bytes differ only on mask-0 bits
      cases[1] = '{pattern: 64'h3e81_c35a, mask: 64'h00ff_0ff0, len: 8'd4, npulses: 8'd2,
                   delay: {20'd0, 20'd0, 20'd1, 20'd2}, width: {17'd1, 17'd1, 17'd2, 17'd4},
                   do_arm: 1'b1, nfill: 8'd4, pkt: 64'h0081_3355, nbytes: 8'd4,
                   split: 1'b0, gap_at: 8'd0, echo: 1'b0, expect_trig: 1'b1};
      cases[2] = cases[1];
      cases[2].pkt[7:0]    = 8'h45;       // mask-1 bit 4 flipped
      cases[2].expect_trig = 1'b0;
      // four pulses, multi-byte delay, zero width read as one
      cases[3] = '{pattern: 64'h2499, mask: 64'hffff, len: 8'd2, npulses: 8'd4,
                   delay: {20'd1, 20'd2, 20'd0, 20'h00103}, width: {17'd0, 17'd3, 17'd1, 17'd2},
                   do_arm: 1'b1, nfill: 8'd5, pkt: 64'h2499, nbytes: 8'd2,
                   split: 1'b0, gap_at: 8'd0, echo: 1'b0, expect_trig: 1'b1};
      cases[4] = cases[0];
      cases[4].split       = 1'b1;        // pattern spread over two packets
      cases[4].gap_at      = 8'd1;
      cases[4].expect_trig = 1'b0;
      cases[5] = cases[0];
      cases[5].delay[0]    = 20'd0;
      cases[5].width[0]    = 17'd2;
      cases[5].nfill       = 8'd1;
      cases[6] = cases[5];
      cases[6].do_arm      = 1'b0;        // second occurrence, still disarmed
      cases[6].expect_trig = 1'b0;
      // one-byte pattern hit on two back-to-back bytes
      cases[7] = cases[0];
      cases[7].pattern     = 64'h5a;
      cases[7].mask        = 64'hff;
      cases[7].len         = 8'd1;
      cases[7].pkt         = 64'h5a;
      cases[7].nbytes      = 8'd1;
      cases[7].echo        = 1'b1;
   endtask

   initial begin
      fe_data     = 8'h00;
      fe_rxvalid  = 1'b0;
      fe_rxactive = 1'b0;
      reg_addr    = 8'h00;
      reg_wdata   = 8'h00;
      reg_write   = 1'b0;
      trig_q      = 1'b0;
      load_cases();
      limit = 100;
      for (int i = 0; i < num_cases; i++)
         limit += 60 + int'(cases[i].nfill) + int'(cases[i].nbytes) + pulse_span(cases[i]);
      do
         tick();
      while (rst);
      tick();
      check(cw_trig === 1'b0 && led_arm === 1'b0 && pulse_count === 4'd0,
            "outputs not idle after reset");
      for (int i = 0; i < num_cases; i++)
         run_case(i);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: flist.f
src/pw_pkg.sv
src/match_cfg_if.sv
src/pw_reg_file.sv
src/pattern_matcher.sv
src/trigger_pulse_stage.sv
src/trigger_output.sv
src/phywhisperer_top.sv
tb/tb_clk_gen.sv
tb/phywhisperer_props.sv
tb/phywhisperer_tb.sv
